/* ks10.f */
ks10Pkg.sv
execUnit.sv
consoleIntf.sv
apr.sv
priIntr.sv
nxm.sv
cpu.sv
cpuChecker.sv
cpuTb.sv

/* cpuTb.sv */
// Testbench top with clock, reset, memory model, console and interrupt tests
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

   localparam int nxmTimeout  = 16;
   localparam int timerPeriod = 200;
   localparam int memWords    = 4096;
   localparam int numTests    = 6;
   localparam int progLen     = 120;                       // Words over all programs
   localparam int timeoutCycles = progLen * 40 + numTests * 500;

   logic clk, rstN, cslSet, cslRun, cslCont, cslExec, cslTimerEn, cslIntrIn, cslIntrOut;
   logic cpuReq, cpuAck, cpuHalt, cpuRun, cpuExec, cpuCont;
   ks10Pkg::intrReq_t ubaIntr;
   ks10Pkg::busAddr_t cpuAddr;
   ks10Pkg::word_t    cpuWrData, cpuRdData;
   ks10Pkg::word_t    mem [memWords];
   int   ackDelay, cycleCount, readAcks, localErr, errBase, passCount, failCount, seedVal;
   int   expReads;                                         // Bus reads a random program needs
   logic memBusy;
   ks10Pkg::addr_t firstFetch;

   cpu #(.nxmTimeout(nxmTimeout), .timerPeriod(timerPeriod)) dut_i (
      .clk(clk), .rstN(rstN), .cslSet(cslSet), .cslRun(cslRun), .cslCont(cslCont),
      .cslExec(cslExec), .cslTimerEn(cslTimerEn), .cslIntrIn(cslIntrIn),
      .cslIntrOut(cslIntrOut), .ubaIntr(ubaIntr), .cpuReq(cpuReq), .cpuAck(cpuAck),
      .cpuAddr(cpuAddr), .cpuWrData(cpuWrData), .cpuRdData(cpuRdData),
      .cpuHalt(cpuHalt), .cpuRun(cpuRun), .cpuExec(cpuExec), .cpuCont(cpuCont));

   cpuChecker #(.nxmTimeout(nxmTimeout)) chk_i (
      .clk(clk), .rstN(rstN), .cpuReq(cpuReq), .cpuAck(cpuAck), .cpuAddr(cpuAddr),
      .cpuWrData(cpuWrData), .cpuRdData(cpuRdData));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Memory model, 0 to 5 cycles latency
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      if (cpuAck) begin
         cpuAck    = 1'b0;
         cpuRdData = '0;                     // Bus idles at zero
         memBusy   = 1'b0;
      end else if (cpuReq && cpuAddr.addr < memWords) begin
         if (!memBusy) begin
            memBusy  = 1'b1;
            ackDelay = $urandom % 6;
         end
         if (ackDelay == 0) begin
            cpuAck = 1'b1;
            if (cpuAddr.write) begin
               mem[cpuAddr.addr] = cpuWrData;
               // Device drops its request once its slot is written
               if (cpuAddr.addr >= 34 && cpuAddr.addr <= 46 && !cpuAddr.addr[0])
                  ubaIntr[(cpuAddr.addr - 32) / 2] = 1'b0;
            end else begin
               cpuRdData = mem[cpuAddr.addr];
            end
         end else begin
            ackDelay--;
         end
      end
   end

   // Read counter and run limit
   always @(posedge clk) begin
      if (cpuReq && cpuAck && !cpuAddr.write) begin
         if (readAcks == 0) firstFetch = cpuAddr.addr;
         readAcks++;
      end
      cycleCount++;
      if (cycleCount > timeoutCycles) begin
         $display("Timeout: run exceeded %0d cycles", timeoutCycles);
         $display("** FAIL **");
         $finish;
      end
   end

   function automatic ks10Pkg::word_t instr(input ks10Pkg::opcode_t op, input int ac,
                                            input int e);
      return {op, 4'(ac), 10'b0, 18'(e)};
   endfunction

   task automatic expectEqual(input string what, input ks10Pkg::word_t exp,
                              input ks10Pkg::word_t act);
      if (act !== exp) begin
         localErr++;
         $display("Mismatch %s %s: expected %o, actual %o", chk_i.testName, what, exp, act);
      end
   endtask

   task automatic beginTest(input string name);
      chk_i.testName = name;
      errBase  = chk_i.errCount;
      localErr = 0;
      readAcks = 0;
      for (int i = 0; i < memWords; i++) mem[i] = '0;   // Zero word is HALT
   endtask

   task automatic endTest;
      int errs;
      errs = localErr + chk_i.errCount - errBase;
      if (errs == 0) passCount++;
      else failCount++;
      $display("Test %s: %s (%0d errors)", chk_i.testName, errs == 0 ? "ok" : "bad", errs);
   endtask

   task automatic resetCore;
      @(negedge clk) rstN = 1'b0;
      repeat (3) @(negedge clk);
      rstN = 1'b1;
   endtask

   task automatic console(input logic run, input logic exec, input logic cont);
      @(negedge clk);
      {cslSet, cslRun, cslExec, cslCont} = {1'b1, run, exec, cont};
      @(negedge clk);
      {cslSet, cslRun, cslExec, cslCont} = '0;
   endtask

   task automatic waitHalt;                   // Bounded by the cycle limit
      while (cpuHalt) @(negedge clk);
      while (!cpuHalt) @(negedge clk);
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   initial begin
      {rstN, cslSet, cslRun, cslCont, cslExec, cslTimerEn, cslIntrIn} = '0;
      {ubaIntr, cpuAck, cpuRdData, memBusy} = '0;
      {cycleCount, passCount, failCount, ackDelay} = '0;
      seedVal = $urandom(32'hedbb);

      beginTest("reset");
      resetCore;
      expectEqual("cpuReq", 0, cpuReq);
      expectEqual("cpuHalt", 1, cpuHalt);
      expectEqual("cpuRun", 0, cpuRun);
      expectEqual("cpuExec", 0, cpuExec);
      expectEqual("cpuCont", 0, cpuCont);
      expectEqual("cslIntrOut", 0, cslIntrOut);
      mem[0] = instr(ks10Pkg::opMovei, 1, 5);
      mem[1] = instr(ks10Pkg::opMovem, 1, 300);
      console(1, 0, 0);
      expectEqual("cpuRun in run", 1, cpuRun);
      waitHalt;
      expectEqual("cpuRun at halt", 0, cpuRun);
      expectEqual("first fetch", 0, firstFetch);
      expectEqual("stored word", 5, mem[300]);
      endTest;

      beginTest("random");
      for (int i = 0; i < 64; i++) mem[1024 + i] = {$urandom, $urandom};
      for (int i = 0; i < 4; i++) mem[i] = instr(ks10Pkg::opMovei, i, $urandom);
      for (int i = 4; i < 44; i++)
         mem[i] = instr(ks10Pkg::opcode_t'(1 + $urandom % 5), $urandom % 4,
                        1024 + $urandom % 64);
      resetCore;
      console(1, 0, 0);
      waitHalt;
      expReads = 45;                                          // Every word up to the HALT
      for (int i = 4; i < 44; i++)
         if (mem[i][35:32] == ks10Pkg::opMove || mem[i][35:32] == ks10Pkg::opAdd ||
             mem[i][35:32] == ks10Pkg::opAnd)
            expReads++;                                       // Operand read
      expectEqual("bus reads", expReads, readAcks);
      endTest;

      beginTest("nxm");
      mem[0]   = instr(ks10Pkg::opMove, 1, 18'o400000);     // Beyond memory
      mem[1]   = instr(ks10Pkg::opMovem, 1, 310);
      mem[310] = '1;
      resetCore;
      console(1, 0, 0);
      waitHalt;
      expectEqual("nxm read data", 0, mem[310]);
      expectEqual("cslIntrOut", 1, cslIntrOut);
      endTest;

      beginTest("exec");
      mem[0] = instr(ks10Pkg::opMovei, 1, 7);
      mem[1] = instr(ks10Pkg::opMovem, 1, 200);
      mem[2] = instr(ks10Pkg::opMovei, 2, 3);
      mem[3] = instr(ks10Pkg::opMovem, 2, 201);
      resetCore;
      console(0, 1, 0);
      expectEqual("cpuExec in exec", 1, cpuExec);
      waitHalt;
      expectEqual("fetches in exec", 1, readAcks);
      expectEqual("cpuExec at halt", 0, cpuExec);
      console(0, 0, 1);
      expectEqual("cpuCont in continue", 1, cpuCont);
      waitHalt;
      expectEqual("word 200", 7, mem[200]);
      expectEqual("word 201", 3, mem[201]);
      endTest;

      beginTest("pi");
      mem[0] = instr(ks10Pkg::opCono, 0, (1 << 11) | (1 << 13) | (1 << 15));
      for (int i = 1; i < 9; i++) mem[i] = instr(ks10Pkg::opMovei, 1, i);
      mem[43] = instr(ks10Pkg::opMovei, 2, 1);                // Level 5 handler
      mem[44] = instr(ks10Pkg::opMovei, 2, 2);                // Also the level 6 slot
      mem[45] = instr(ks10Pkg::opCono, 0, (1 << 16) | (1 << 11) | (1 << 13) | (1 << 15));
      mem[46] = instr(ks10Pkg::opMovei, 3, 5);                // Level 7 slot
      mem[47] = instr(ks10Pkg::opMovei, 3, 9);
      resetCore;
      ubaIntr = 7'b1110000;                                   // Levels 5, 6 and 7
      console(1, 0, 0);
      waitHalt;
      expectEqual("level 6 slot", instr(ks10Pkg::opMovei, 2, 2), mem[44]);
      expectEqual("level 7 save", 47, mem[46]);
      if (mem[42] < 1 || mem[42] > 9) begin
         localErr++;
         $display("Error pi: level 5 save slot holds %o", mem[42]);
      end
      ubaIntr = '0;
      endTest;

      beginTest("timer");
      mem[0] = instr(ks10Pkg::opCono, 0, 7 | (1 << 15));      // APR on level 7
      for (int i = 1; i < 46; i++) mem[i] = instr(ks10Pkg::opMove, 1, 1000);
      mem[47] = instr(ks10Pkg::opCono, 0, 7 | (1 << 7) | (1 << 15) | (1 << 16));
      mem[48] = instr(ks10Pkg::opMovei, 2, 1);                // Boundary with level 7 free
      mem[1000] = 36'o123;
      resetCore;
      cslTimerEn = 1'b1;
      console(1, 0, 0);
      waitHalt;
      if (mem[46] < 2 || mem[46] > 46) begin
         localErr++;
         $display("Error timer: interrupt not taken, save slot holds %o", mem[46]);
      end
      cslTimerEn = 1'b0;
      endTest;

      $display("Tests %0d, passed %0d, failed %0d", numTests, passCount, failCount);
      if (failCount == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* cpuChecker.sv */
// Bus monitor with a reference model of the core and value comparisons
`timescale 1ns/1ps
`default_nettype none

module cpuChecker #(
   parameter int nxmTimeout = 16
) (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire                     cpuReq,
   input  wire                     cpuAck,
   input  wire ks10Pkg::busAddr_t  cpuAddr,
   input  wire ks10Pkg::word_t     cpuWrData,
   input  wire ks10Pkg::word_t     cpuRdData
);

   string            testName = "none";   // Set by the testbench per test
   int               errCount = 0;
   ks10Pkg::word_t   acModel [16];
   ks10Pkg::addr_t   pcModel;
   ks10Pkg::word_t   irModel;             // Last fetched instruction
   logic [7:1]       maskModel;
   int               curModel;            // Level in service
   logic             wantOperand;
   logic             wantStore;
   int               waitCnt;             // Cycles of the pending request

   task automatic compare(input string what, input ks10Pkg::word_t exp,
                          input ks10Pkg::word_t act);
      if (act !== exp) begin
         errCount++;
         $display("Mismatch %s %s: expected %o, actual %o", testName, what, exp, act);
      end
   endtask

   //////////////////////////////////////////////////
   // One finished bus cycle
   //////////////////////////////////////////////////

   task automatic busCycle(input ks10Pkg::word_t rd);
      int lvl;
      ks10Pkg::acNum_t a;
      a = irModel[31:28];
      if (wantOperand) begin
         compare("operand address", 36'(irModel[17:0]), 36'(cpuAddr.addr));
         case (irModel[35:32])
            ks10Pkg::opMove: acModel[a] = rd;
            ks10Pkg::opAdd:  acModel[a] = acModel[a] + rd;   // 36-bit wrap
            ks10Pkg::opAnd:  acModel[a] = acModel[a] & rd;
            default: ;
         endcase
         wantOperand = 1'b0;
      end else if (wantStore) begin
         compare("store address", 36'(irModel[17:0]), 36'(cpuAddr.addr));
         compare("store data", acModel[a], cpuWrData);
         wantStore = 1'b0;
      end else if (!cpuAddr.write) begin
         // Instruction fetch
         compare("fetch address", 36'(pcModel), 36'(cpuAddr.addr));
         pcModel = pcModel + 1'b1;
         irModel = rd;
         a = rd[31:28];
         case (rd[35:32])
            ks10Pkg::opMovei: acModel[a] = 36'(rd[17:0]);
            ks10Pkg::opMove, ks10Pkg::opAdd, ks10Pkg::opAnd: wantOperand = 1'b1;
            ks10Pkg::opMovem: wantStore = 1'b1;
            ks10Pkg::opCono: begin
               maskModel = rd[15:9];
               if (rd[16]) curModel = 0;         // Dismiss
            end
            default: ;                           // HALT
         endcase
      end else begin
         // Write at a boundary is an interrupt save
         lvl = (int'(cpuAddr.addr) - int'(ks10Pkg::intrBase)) / 2;
         if (lvl < 1 || lvl > 7 || cpuAddr.addr[0]) begin
            errCount++;
            $display("Error %s: unexpected write to %o", testName, cpuAddr.addr);
         end else begin
            if (!maskModel[lvl]) begin
               errCount++;
               $display("Error %s: interrupt taken at masked level %0d", testName, lvl);
            end
            if (curModel != 0 && lvl >= curModel) begin
               errCount++;
               $display("Error %s: level %0d taken while level %0d in service",
                        testName, lvl, curModel);
            end
            compare("saved pc", 36'(pcModel), cpuWrData);
            pcModel  = cpuAddr.addr + 1'b1;
            curModel = lvl;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!rstN) begin
         pcModel     = '0;
         maskModel   = '0;
         curModel    = 0;
         wantOperand = 1'b0;
         wantStore   = 1'b0;
         waitCnt     = 0;
      end else if (cpuReq) begin
         // Real ack, or the watchdog ends it with zero data
         if (cpuAck || waitCnt == nxmTimeout - 1) begin
            busCycle(cpuAck ? cpuRdData : '0);
            waitCnt = 0;
         end else begin
            waitCnt++;
         end
      end else begin
         waitCnt = 0;
      end
   end

endmodule

`default_nettype wire

/* cpu.sv */
// Core top level wiring the execution unit, console, APR, PI and NXM blocks
`timescale 1ns/1ps
`default_nettype none

module cpu #(
   parameter int nxmTimeout  = 16,    // Cycles before a bus cycle is forced to end
   parameter int timerPeriod = 200    // Interval timer period in clocks
) (
   input  wire                     clk,
   input  wire                     rstN,
   // Console
   input  wire                     cslSet,       // Strobe for run, exec, cont
   input  wire                     cslRun,
   input  wire                     cslCont,
   input  wire                     cslExec,
   input  wire                     cslTimerEn,
   input  wire                     cslIntrIn,    // Console to CPU
   output logic                    cslIntrOut,   // CPU to console
   // Unibus
   input  wire ks10Pkg::intrReq_t  ubaIntr,
   // Memory bus
   output logic                    cpuReq,
   input  wire                     cpuAck,
   output ks10Pkg::busAddr_t       cpuAddr,
   output ks10Pkg::word_t          cpuWrData,
   input  wire ks10Pkg::word_t     cpuRdData,    // Idles at zero when no slave answers
   // Status
   output logic                    cpuHalt,
   output logic                    cpuRun,
   output logic                    cpuExec,
   output logic                    cpuCont
);

   logic               busAck;       // Real or forced ack
   logic               nxmSet;
   logic               halted;
   logic               runEn;
   logic               stepEn;
   logic               intrPending;
   ks10Pkg::level_t    reqLevel;
   logic               intrAck;
   logic               conoWr;
   ks10Pkg::word_t     conoData;
   ks10Pkg::intrReq_t  aprIntr;

   //////////////////////////////////////////////////
   // Sequencing and datapath
   //////////////////////////////////////////////////

   execUnit uExec (
      .clk         (clk),
      .rstN        (rstN),
      .runEn       (runEn),
      .stepEn      (stepEn),
      .halted      (halted),
      .busAck      (busAck),
      .busRdData   (cpuRdData),
      .cpuReq      (cpuReq),
      .cpuAddr     (cpuAddr),
      .cpuWrData   (cpuWrData),
      .intrPending (intrPending),
      .reqLevel    (reqLevel),
      .intrAck     (intrAck),
      .conoWr      (conoWr),
      .conoData    (conoData)
   );

   consoleIntf uIntf (
      .clk     (clk),
      .rstN    (rstN),
      .cslSet  (cslSet),
      .cslRun  (cslRun),
      .cslCont (cslCont),
      .cslExec (cslExec),
      .halted  (halted),
      .runEn   (runEn),
      .stepEn  (stepEn),
      .cpuRun  (cpuRun),
      .cpuExec (cpuExec),
      .cpuCont (cpuCont),
      .cpuHalt (cpuHalt)
   );

   //////////////////////////////////////////////////
   // Interrupt sources and arbiter
   //////////////////////////////////////////////////

   apr #(.timerPeriod(timerPeriod)) uApr (
      .clk        (clk),
      .rstN       (rstN),
      .cslTimerEn (cslTimerEn),
      .cslIntrIn  (cslIntrIn),
      .nxmSet     (nxmSet),
      .conoWr     (conoWr),
      .conoData   (conoData),
      .aprIntr    (aprIntr),
      .cslIntrOut (cslIntrOut)
   );

   priIntr uPi (
      .clk         (clk),
      .rstN        (rstN),
      .aprIntr     (aprIntr),
      .ubaIntr     (ubaIntr),
      .conoWr      (conoWr),
      .conoData    (conoData),
      .intrAck     (intrAck),
      .intrPending (intrPending),
      .reqLevel    (reqLevel)
   );

   // Bus watchdog, merges the external ack
   nxm #(.nxmTimeout(nxmTimeout)) uNxm (
      .clk    (clk),
      .rstN   (rstN),
      .cpuReq (cpuReq),
      .cpuAck (cpuAck),
      .ackOut (busAck),
      .nxmSet (nxmSet)
   );

endmodule

`default_nettype wire

/* nxm.sv */
// Non-existent memory watchdog with forced bus ack
`timescale 1ns/1ps
`default_nettype none

module nxm #(
   parameter int nxmTimeout = 16
) (
   input  wire   clk,
   input  wire   rstN,
   input  wire   cpuReq,
   input  wire   cpuAck,
   output logic  ackOut,     // Ack seen by execUnit
   output logic  nxmSet      // Timeout pulse to APR
);

   localparam int cntW = $clog2(nxmTimeout + 1);

   logic [cntW-1:0] waitCnt;    // Cycles of the current request
   logic            expired;

   // Last allowed wait cycle with no answer
   assign expired = cpuReq && !cpuAck && (waitCnt == cntW'(nxmTimeout - 1));

   assign ackOut = cpuAck | expired;
   assign nxmSet = expired;

   always_ff @(posedge clk) begin
      if (!rstN || !cpuReq || ackOut)
         waitCnt <= '0;         // Fresh count per cycle
      else
         waitCnt <= waitCnt + 1'b1;
   end

endmodule

`default_nettype wire

/* priIntr.sv */
// Seven level priority interrupt arbiter with enable mask and current level
`timescale 1ns/1ps
`default_nettype none

module priIntr (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire ks10Pkg::intrReq_t  aprIntr,
   input  wire ks10Pkg::intrReq_t  ubaIntr,
   input  wire                     conoWr,
   input  wire ks10Pkg::word_t     conoData,
   input  wire                     intrAck,      // Level taken by execUnit
   output logic                    intrPending,
   output ks10Pkg::level_t         reqLevel
);

   ks10Pkg::intrReq_t  enMask;
   ks10Pkg::intrReq_t  pending;
   ks10Pkg::level_t    curLevel;     // Level in service, 0 is none

   assign pending = (aprIntr | ubaIntr) & enMask;

   // Fixed priority, level 1 wins
   // Only levels above the one in service
   always_comb begin
      reqLevel = '0;
      for (int i = 7; i >= 1; i--) begin
         if (pending[i] && (curLevel == '0 || i < curLevel))
            reqLevel = ks10Pkg::level_t'(i);
      end
   end

   assign intrPending = (reqLevel != '0);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         enMask   <= '0;           // Everything masked
         curLevel <= '0;
      end else begin
         if (conoWr) begin
            enMask <= conoData[15:9];
            if (conoData[16])
               curLevel <= '0;     // Dismiss
         end
         if (intrAck)
            curLevel <= reqLevel;
      end
   end

   // execUnit takes a level only when one is offered
   aAckPending: assert property (@(posedge clk) disable iff (!rstN)
      intrAck |-> intrPending)
      else $error("intrAck without intrPending");

endmodule

`default_nettype wire

/* apr.sv */
// APR flags, interval timer and APR interrupt request
`timescale 1ns/1ps
`default_nettype none

module apr #(
   parameter int timerPeriod = 200
) (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire                    cslTimerEn,
   input  wire                    cslIntrIn,
   input  wire                    nxmSet,       // Pulse from watchdog
   input  wire                    conoWr,
   input  wire ks10Pkg::word_t    conoData,
   output ks10Pkg::intrReq_t      aprIntr,
   output logic                   cslIntrOut
);

   localparam int tmrW = $clog2(timerPeriod + 1);

   ks10Pkg::aprFlags_t  flags;
   logic [tmrW-1:0]     tmrCnt;
   logic                tmrWrap;
   logic                anyFlag;

   assign tmrWrap = cslTimerEn && (tmrCnt == tmrW'(timerPeriod - 1));

   // Interval counter, parked at zero while disabled
   always_ff @(posedge clk) begin
      if (!rstN || !cslTimerEn || tmrWrap)
         tmrCnt <= '0;
      else
         tmrCnt <= tmrCnt + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         flags <= '0;
      end else begin
         if (conoWr) begin
            flags.level <= conoData[2:0];
            if (conoData[8]) flags.nxm       <= 1'b0;
            if (conoData[7]) flags.timerDone <= 1'b0;
            if (conoData[6]) flags.cslIntr   <= 1'b0;
         end
         // Sets beat clears
         if (nxmSet)    flags.nxm       <= 1'b1;
         if (tmrWrap)   flags.timerDone <= 1'b1;
         if (cslIntrIn) flags.cslIntr   <= 1'b1;
      end
   end

   assign anyFlag = flags.nxm | flags.timerDone | flags.cslIntr;

   // One request bit at the programmed level
   always_comb begin
      aprIntr = '0;
      if (anyFlag && flags.level != '0)
         aprIntr[flags.level] = 1'b1;
   end

   assign cslIntrOut = flags.nxm;     // Console learns of bus errors

endmodule

`default_nettype wire

/* consoleIntf.sv */
// Console run, exec and continue mode latches with halt status
`timescale 1ns/1ps
`default_nettype none

module consoleIntf (
   input  wire   clk,
   input  wire   rstN,
   input  wire   cslSet,     // Load mode bits
   input  wire   cslRun,
   input  wire   cslCont,
   input  wire   cslExec,
   input  wire   halted,     // From execUnit
   output logic  runEn,
   output logic  stepEn,
   output logic  cpuRun,
   output logic  cpuExec,
   output logic  cpuCont,
   output logic  cpuHalt
);

   logic haltRise;   // Machine just stopped

   // cpuHalt is last cycle's halted
   assign haltRise = halted & ~cpuHalt;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         cpuRun  <= 1'b0;
         cpuExec <= 1'b0;
         cpuCont <= 1'b0;
         cpuHalt <= 1'b1;        // Comes up stopped
      end else begin
         cpuHalt <= halted;
         if (cslSet) begin
            cpuRun  <= cslRun;
            cpuExec <= cslExec;
            cpuCont <= cslCont;
         end else if (haltRise) begin
            // Every mode ends at a halt
            cpuRun  <= 1'b0;
            cpuExec <= 1'b0;
            cpuCont <= 1'b0;
         end
      end
   end

   // Blocked in the halt cycle so a stale mode bit cannot restart
   assign runEn  = (cpuRun | cpuExec | cpuCont) & ~haltRise;
   assign stepEn = cpuExec;                   // One instruction then stop

endmodule

`default_nettype wire

/* execUnit.sv */
// Fetch and execute FSM with PC, accumulator file and interrupt save cycle
`timescale 1ns/1ps
`default_nettype none

module execUnit (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire                    runEn,        // Console go
   input  wire                    stepEn,       // Stop after one instruction
   output logic                   halted,
   input  wire                    busAck,
   input  wire ks10Pkg::word_t    busRdData,
   output logic                   cpuReq,
   output ks10Pkg::busAddr_t      cpuAddr,
   output ks10Pkg::word_t         cpuWrData,
   input  wire                    intrPending,
   input  wire ks10Pkg::level_t   reqLevel,
   output logic                   intrAck,      // Level taken
   output logic                   conoWr,
   output ks10Pkg::word_t         conoData
);

   ks10Pkg::execState_t  state;
   ks10Pkg::addr_t       pc;
   ks10Pkg::word_t       ir;            // Instruction register
   ks10Pkg::word_t       operand;       // C(E) from read cycle
   ks10Pkg::word_t       acs [16];      // Accumulator file
   ks10Pkg::opcode_t     op;
   ks10Pkg::acNum_t      acSel;
   ks10Pkg::addr_t       ea;            // No indexing, E is the address field
   ks10Pkg::addr_t       saveAddr;
   logic                 needRead;
   logic                 toHalt;
   logic                 takeIntr;

   // Instruction fields
   assign op       = ks10Pkg::opcode_t'(ir[35:32]);
   assign acSel    = ir[31:28];
   assign ea       = ir[17:0];
   assign needRead = op inside {ks10Pkg::opMove, ks10Pkg::opAdd, ks10Pkg::opAnd};

   // Save slot is 40 + 2*level
   assign saveAddr = ks10Pkg::intrBase + ks10Pkg::addr_t'({reqLevel, 1'b0});

   // Instruction boundary decisions, made in EXEC only
   assign toHalt   = (state == ks10Pkg::stExec) && (stepEn || op == ks10Pkg::opHalt);
   assign takeIntr = (state == ks10Pkg::stExec) && !toHalt && intrPending;
   assign intrAck  = takeIntr;

   assign halted   = (state == ks10Pkg::stHalted);
   assign conoWr   = (state == ks10Pkg::stExec) && (op == ks10Pkg::opCono);
   assign conoData = ks10Pkg::word_t'(ea);    // Immediate operand

   //////////////////////////////////////////////////
   // Control FSM and bus request
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state   <= ks10Pkg::stHalted;
         pc      <= '0;
         cpuReq  <= 1'b0;
         cpuAddr <= '0;
      end else begin
         case (state)
            ks10Pkg::stHalted, ks10Pkg::stIdle: begin
               if (runEn) begin
                  state   <= ks10Pkg::stFetch;
                  cpuReq  <= 1'b1;
                  cpuAddr <= '{write: 1'b0, addr: pc};
               end else begin
                  state <= ks10Pkg::stHalted;
               end
            end
            ks10Pkg::stFetch: if (busAck) begin
               cpuReq <= 1'b0;
               pc     <= pc + 1'b1;
               state  <= ks10Pkg::stDecode;
            end
            ks10Pkg::stDecode: begin
               if (op == ks10Pkg::opMovem) begin
                  state   <= ks10Pkg::stWrite;
                  cpuReq  <= 1'b1;
                  cpuAddr <= '{write: 1'b1, addr: ea};
               end else if (needRead) begin
                  state   <= ks10Pkg::stRead;
                  cpuReq  <= 1'b1;
                  cpuAddr <= '{write: 1'b0, addr: ea};
               end else begin
                  state <= ks10Pkg::stExec;   // HALT, MOVEI, CONO
               end
            end
            ks10Pkg::stRead, ks10Pkg::stWrite: if (busAck) begin
               cpuReq <= 1'b0;
               state  <= ks10Pkg::stExec;
            end
            ks10Pkg::stExec: begin
               if (toHalt) begin
                  state <= ks10Pkg::stHalted;
               end else if (takeIntr) begin
                  state   <= ks10Pkg::stIntrSave;
                  cpuReq  <= 1'b1;
                  cpuAddr <= '{write: 1'b1, addr: saveAddr};
               end else if (runEn) begin
                  state   <= ks10Pkg::stFetch;
                  cpuReq  <= 1'b1;
                  cpuAddr <= '{write: 1'b0, addr: pc};
               end else begin
                  state <= ks10Pkg::stHalted;
               end
            end
            ks10Pkg::stIntrSave: if (busAck) begin
               cpuReq <= 1'b0;
               pc     <= cpuAddr.addr + 1'b1;   // Resume after the save slot
               state  <= ks10Pkg::stIdle;
            end
            default: state <= ks10Pkg::stHalted;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (state == ks10Pkg::stFetch && busAck)
         ir <= busRdData;
      if (state == ks10Pkg::stRead && busAck)
         operand <= busRdData;
      if (state == ks10Pkg::stDecode && op == ks10Pkg::opMovem)
         cpuWrData <= acs[acSel];
      if (takeIntr)
         cpuWrData <= ks10Pkg::word_t'(pc);    // Return address
      if (state == ks10Pkg::stExec) begin
         case (op)
            ks10Pkg::opMovei: acs[acSel] <= ks10Pkg::word_t'(ea);
            ks10Pkg::opMove:  acs[acSel] <= operand;
            ks10Pkg::opAdd:   acs[acSel] <= acs[acSel] + operand;   // Wraps at 36 bits
            ks10Pkg::opAnd:   acs[acSel] <= acs[acSel] & operand;
            default: ;
         endcase
      end
   end

   // Address held for the whole wait
   aAddrHold: assert property (@(posedge clk) disable iff (!rstN)
      cpuReq && !busAck |=> cpuReq && $stable(cpuAddr))
      else $error("cpuAddr changed while cpuReq waited");

   // No bus activity out of halt without a go
   aNoReqHalted: assert property (@(posedge clk) disable iff (!rstN)
      state == ks10Pkg::stHalted && !runEn |=> !cpuReq)
      else $error("cpuReq raised from HALTED");

endmodule

`default_nettype wire

/* ks10Pkg.sv */
// Machine word, address, interrupt, opcode, state and bus types for the core
`default_nettype none

package ks10Pkg;

   //////////////////////////////////////////////////
   // Plain widths
   //////////////////////////////////////////////////

   typedef logic [35:0] word_t;      // 36-bit machine word
   typedef logic [17:0] addr_t;      // 18-bit physical address
   typedef logic [3:0]  acNum_t;     // Accumulator select
   typedef logic [2:0]  level_t;     // PI level, 0 is none
   typedef logic [7:1]  intrReq_t;   // One bit per level, index is level

   // Interrupt save slots start at 40 octal
   localparam addr_t intrBase = 18'o40;

   //////////////////////////////////////////////////
   // Instruction decode
   //////////////////////////////////////////////////

   // Opcode lives in word bits 35:32
   // AC field in 31:28, address field in 17:0
   typedef enum logic [3:0] {
      opHalt  = 4'd0,   // Stop, console sees halt
      opMovei = 4'd1,   // AC gets E
      opMove  = 4'd2,   // AC gets C(E)
      opMovem = 4'd3,   // C(E) gets AC
      opAdd   = 4'd4,   // AC gets AC + C(E)
      opAnd   = 4'd5,   // AC gets AC and C(E)
      opCono  = 4'd6    // PI mask, APR level and flag clears
   } opcode_t;

   // Execution unit sequencing
   typedef enum logic [2:0] {
      stIdle,           // Bus turnaround after interrupt save
      stFetch,          // Instruction read
      stDecode,
      stRead,           // Operand read
      stExec,
      stWrite,          // MOVEM store
      stIntrSave,       // PC to save slot
      stHalted
   } execState_t;

   //////////////////////////////////////////////////
   // Bus and APR
   //////////////////////////////////////////////////

   // Address phase of the memory bus
   typedef struct packed {
      logic  write;     // 1 for store, 0 for read
      addr_t addr;
   } busAddr_t;

   // APR status
   typedef struct packed {
      logic   nxm;          // Bus cycle timed out
      logic   timerDone;    // Interval timer expired
      logic   cslIntr;      // Console asked for attention
      level_t level;        // PI level for APR requests
   } aprFlags_t;

endpackage

`default_nettype wire
